// File: logic/harness_pkg.sv
/*
  Harness package
  Bus widths, memory map, boot ROM image and debug hold-off length
  shared by the memory side and the debug side of the harness.
*/
package harness_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned WordLsb   = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  typedef enum logic [1:0] {
    RegionRom,
    RegionRam,
    RegionNone
  } region_e;

  // ----------------------------------------------------------------------
  // Memory map
  // ----------------------------------------------------------------------
  localparam addr_t       RomBase     = 32'h0000_1000;
  localparam int unsigned RomWords    = 8;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam addr_t       RomBytes    = addr_t'(RomWords * StrbWidth);

  localparam addr_t       RamBase     = 32'h8000_0000;
  localparam int unsigned RamWords    = 256;
  localparam int unsigned RamIdxWidth = $clog2(RamWords);
  localparam addr_t       RamBytes    = addr_t'(RamWords * StrbWidth);

  // Boot code, jumps into RAM after a few setup words
  localparam data_t RomImage [RomWords] = '{
    32'h0000_0297,
    32'h0182_8293,
    32'h0002_a303,
    32'h0010_0093,
    32'h0003_0067,
    32'h0000_0013,
    32'h8000_0000,
    32'hdead_beef
  };

  // ----------------------------------------------------------------------
  // Debug
  // ----------------------------------------------------------------------
  // Cycles after reset release before a debug request may pass
  localparam int unsigned DebugHoldCycles = 32;
  localparam int unsigned HoldCntWidth    = $clog2(DebugHoldCycles + 1);

  localparam int unsigned ExitWidth = 32;

  typedef logic [ExitWidth-1:0] exit_t;

endpackage

// File: logic/addr_decoder.sv
/*
  Address decoder
  Matches a host address against the ROM and RAM windows and returns
  the region and the word offset inside it. ROM writes are rejected.
*/
`timescale 1ns/10ps

module addr_decoder import harness_pkg::*; (
  input  addr_t                  addr_i,
  input  logic                   we_i,
  output region_e                region_o,
  output logic                   err_o,
  output logic [RamIdxWidth-1:0] word_idx_o
);

  addr_t rom_off;
  addr_t ram_off;
  logic  in_rom;
  logic  in_ram;

  // Offsets relative to each region base
  assign rom_off = addr_i - RomBase;
  assign ram_off = addr_i - RamBase;

  assign in_rom = (rom_off < RomBytes);
  assign in_ram = (ram_off < RamBytes);

  always_comb begin
    region_o   = RegionNone;
    word_idx_o = '0;
    if (in_rom && !we_i) begin
      region_o   = RegionRom;
      word_idx_o = rom_off[WordLsb +: RamIdxWidth];
    end else if (in_ram) begin
      region_o   = RegionRam;
      word_idx_o = ram_off[WordLsb +: RamIdxWidth];
    end
    // Unmapped or write to ROM
    err_o = (region_o == RegionNone);
  end

endmodule

// File: logic/bootrom.sv
/*
  Boot ROM
  Fixed word table from the package with a registered read port.
*/
`timescale 1ns/10ps

module bootrom import harness_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [RomIdxWidth-1:0] word_i,
  output data_t                  rdata_o
);

  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= RomImage[word_i];
    end
  end

  assign rdata_o = rdata_q;

  a_word_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown(word_i)
  ) else $error("bootrom word index unknown on a read");

endmodule

// File: logic/sram_bank.sv
/*
  SRAM bank
  Single-port RAM with byte enables, addressed by word offset.
  Reads are registered, writes land at the request edge.
*/
`timescale 1ns/10ps

module sram_bank import harness_pkg::*; #(
  parameter int unsigned NumWords = RamWords
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] word_i,
  input  strb_t                       be_i,
  input  data_t                       wdata_i,
  output data_t                       rdata_o
);

  data_t mem_q [NumWords];
  data_t rdata_q;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_i];
      end
    end
  end

  assign rdata_o = rdata_q;

  a_be_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_i && we_i) |-> !$isunknown(be_i)
  ) else $error("sram_bank byte enables unknown during write");

endmodule

// File: logic/mem_subsystem.sv
/*
  Memory subsystem
  Decodes host requests, steers them to the boot ROM or the RAM and
  returns read data or an error response one cycle later.
*/
`timescale 1ns/10ps

module mem_subsystem import harness_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  strb_t be_i,
  input  data_t wdata_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o
);

  region_e                region;
  logic                   dec_err;
  logic [RamIdxWidth-1:0] word_idx;
  logic                   rom_req;
  logic                   ram_req;
  data_t                  rom_rdata;
  data_t                  ram_rdata;

  region_e region_q;
  logic    rvalid_q;
  logic    we_q;
  logic    err_q;

  // ----------------------------------------------------------------------
  // Decode and steer
  // ----------------------------------------------------------------------
  addr_decoder i_addr_decoder (
    .addr_i     ( addr_i   ),
    .we_i       ( we_i     ),
    .region_o   ( region   ),
    .err_o      ( dec_err  ),
    .word_idx_o ( word_idx )
  );

  assign rom_req = req_i && (region == RegionRom);
  assign ram_req = req_i && (region == RegionRam);

  bootrom i_bootrom (
    .clk_i   ( clk_i                      ),
    .rst_ni  ( rst_ni                     ),
    .req_i   ( rom_req                    ),
    .word_i  ( word_idx[RomIdxWidth-1:0] ),
    .rdata_o ( rom_rdata                  )
  );

  sram_bank #(
    .NumWords ( RamWords )
  ) i_sram_bank (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .req_i   ( ram_req   ),
    .we_i    ( we_i      ),
    .word_i  ( word_idx  ),
    .be_i    ( be_i      ),
    .wdata_i ( wdata_i   ),
    .rdata_o ( ram_rdata )
  );

  // ----------------------------------------------------------------------
  // Response pipeline
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      err_q    <= 1'b0;
      region_q <= RegionNone;
    end else begin
      rvalid_q <= req_i;
      we_q     <= we_i;
      err_q    <= req_i && dec_err;
      region_q <= req_i ? region : RegionNone;
    end
  end

  // Data only for reads, zero for writes and errors
  always_comb begin
    rdata_o = '0;
    if (!we_q) begin
      case (region_q)
        RegionRom: rdata_o = rom_rdata;
        RegionRam: rdata_o = ram_rdata;
        default:   rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  a_err_zero_data : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    err_o |-> (rdata_o == '0)
  ) else $error("mem_subsystem error response carries data");

endmodule

// File: logic/debug_port.sv
/*
  Debug port
  Picks the JTAG or DMI debug source, forwards its exit code and lets
  its request strobe through once the post-reset hold-off has ended.
*/
`timescale 1ns/10ps

module debug_port import harness_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  jtag_sel_i,
  input  logic  jtag_req_i,
  input  logic  dmi_req_i,
  input  exit_t jtag_exit_i,
  input  exit_t dmi_exit_i,
  output logic  debug_req_o,
  output exit_t exit_o
);

  logic                    sel_req;
  logic                    hold_done;
  logic [HoldCntWidth-1:0] hold_cnt_q;
  logic                    debug_req_q;

  // Source mux
  assign sel_req = jtag_sel_i ? jtag_req_i : dmi_req_i;
  assign exit_o  = jtag_sel_i ? jtag_exit_i : dmi_exit_i;

  // ----------------------------------------------------------------------
  // Hold-off after reset release
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= HoldCntWidth'(DebugHoldCycles);
    end else if (!hold_done) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign hold_done = (hold_cnt_q == '0);

  // Requests during hold-off are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      debug_req_q <= 1'b0;
    end else begin
      debug_req_q <= sel_req && hold_done;
    end
  end

  assign debug_req_o = debug_req_q;

  a_no_req_in_holdoff : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(debug_req_o) |-> $past(hold_cnt_q == '0)
  ) else $error("debug request raised during hold-off");

endmodule

// File: logic/soc_harness.sv
/*
  SoC harness top
  Joins the host memory subsystem and the debug request port.
*/
`timescale 1ns/10ps

module soc_harness import harness_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Host bus
  input  logic  host_req_i,
  input  logic  host_we_i,
  input  addr_t host_addr_i,
  input  strb_t host_be_i,
  input  data_t host_wdata_i,
  output logic  host_rvalid_o,
  output data_t host_rdata_o,
  output logic  host_err_o,
  // Debug
  input  logic  jtag_sel_i,
  input  logic  jtag_req_i,
  input  logic  dmi_req_i,
  input  exit_t jtag_exit_i,
  input  exit_t dmi_exit_i,
  output logic  debug_req_o,
  output exit_t exit_o
);

  mem_subsystem i_mem_subsystem (
    .clk_i    ( clk_i         ),
    .rst_ni   ( rst_ni        ),
    .req_i    ( host_req_i    ),
    .we_i     ( host_we_i     ),
    .addr_i   ( host_addr_i   ),
    .be_i     ( host_be_i     ),
    .wdata_i  ( host_wdata_i  ),
    .rvalid_o ( host_rvalid_o ),
    .rdata_o  ( host_rdata_o  ),
    .err_o    ( host_err_o    )
  );

  debug_port i_debug_port (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .jtag_sel_i  ( jtag_sel_i  ),
    .jtag_req_i  ( jtag_req_i  ),
    .dmi_req_i   ( dmi_req_i   ),
    .jtag_exit_i ( jtag_exit_i ),
    .dmi_exit_i  ( dmi_exit_i  ),
    .debug_req_o ( debug_req_o ),
    .exit_o      ( exit_o      )
  );

endmodule

// File: sim/harness_checker.sv
/*
  Harness checker
  Compares the DUT responses, debug strobe and exit code with the
  expected values and prints one line per finished test.
*/
`timescale 1ns/10ps

module harness_checker import harness_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rvalid_i,
  input  data_t rdata_i,
  input  logic  err_i,
  input  logic  debug_req_i,
  input  exit_t exit_i,
  input  logic  exp_valid_i,
  input  data_t exp_data_i,
  input  logic  exp_err_i,
  input  logic  exp_debug_i,
  input  exit_t exp_exit_i,
  input  logic  test_done_i,
  input  int    test_id_i,
  output int    errors_o,
  output int    checks_o
);

  logic  exp_valid_q, exp_err_q, exp_debug_q;
  data_t exp_data_q;
  int    errors = 0;
  int    checks = 0;
  int    test_base = 0;

  // Expected response lines up with the one-cycle latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_valid_q <= 1'b0;
      exp_err_q   <= 1'b0;
      exp_debug_q <= 1'b0;
      exp_data_q  <= '0;
    end else begin
      exp_valid_q <= exp_valid_i;
      exp_err_q   <= exp_err_i;
      exp_debug_q <= exp_debug_i;
      exp_data_q  <= exp_data_i;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (exp_valid_q && rvalid_i !== 1'b1) begin
        $display("Error at %0t: response strobe missing after a request", $time);
        errors++;
      end else if (!exp_valid_q && (rvalid_i !== 1'b0 || err_i !== 1'b0)) begin
        $display("Error at %0t: response or error strobe without a request", $time);
        errors++;
      end else if (exp_valid_q) begin
        checks++;
        if (rdata_i !== exp_data_q) begin
          $display("MISMATCH at %0t: host_rdata_o is %h, expected %h",
                   $time, rdata_i, exp_data_q);
          errors++;
        end
        if (err_i !== exp_err_q) begin
          $display("MISMATCH at %0t: host_err_o is %b, expected %b", $time, err_i, exp_err_q);
          errors++;
        end
      end
      if (exp_debug_q && debug_req_i !== 1'b1) begin
        $display("Error at %0t: expected debug request did not arrive", $time);
        errors++;
      end else if (!exp_debug_q && debug_req_i !== 1'b0) begin
        $display("Error at %0t: unexpected debug request", $time);
        errors++;
      end else if (exp_debug_q) begin
        checks++;
      end
      if (exit_i !== exp_exit_i) begin
        $display("MISMATCH at %0t: exit_o is %h, expected %h", $time, exit_i, exp_exit_i);
        errors++;
      end
      if (test_done_i) begin
        $display("Test %0d %s with %0d errors", test_id_i,
                 (errors == test_base) ? "passed" : "failed", errors - test_base);
        test_base = errors;
      end
    end
  end

  assign errors_o = errors;
  assign checks_o = checks;

endmodule

// File: sim/tb_soc_harness.sv
/*
  SoC harness testbench
  Replays bus and debug operations from the stimulus file against the
  harness, with a RAM and ROM reference model and a watchdog.
*/
`timescale 1ns/10ps

module tb_soc_harness import harness_pkg::*; ();

  typedef struct {
    int    test;
    byte   op;
    data_t a0;
    data_t a1;
    data_t a2;
    data_t exp_data;
    logic  exp_flag;
  } op_t;

  logic  clk, rst_n;
  logic  host_req, host_we, host_rvalid, host_err;
  addr_t host_addr;
  strb_t host_be;
  data_t host_wdata, host_rdata;
  logic  jtag_sel, jtag_req, dmi_req, debug_req;
  exit_t jtag_exit, dmi_exit, exit_code;
  logic  exp_valid, exp_err, exp_debug, test_done;
  data_t exp_data;
  exit_t exp_exit;
  int    test_id, err_cnt, chk_cnt;
  int    model_errs = 0;
  bit    ops_loaded = 1'b0;
  op_t   ops[$];
  data_t ram_model [RamWords];

  soc_harness dut0 (
    .clk_i (clk), .rst_ni (rst_n),
    .host_req_i (host_req), .host_we_i (host_we), .host_addr_i (host_addr),
    .host_be_i (host_be), .host_wdata_i (host_wdata), .host_rvalid_o (host_rvalid),
    .host_rdata_o (host_rdata), .host_err_o (host_err),
    .jtag_sel_i (jtag_sel), .jtag_req_i (jtag_req), .dmi_req_i (dmi_req),
    .jtag_exit_i (jtag_exit), .dmi_exit_i (dmi_exit),
    .debug_req_o (debug_req), .exit_o (exit_code)
  );

  harness_checker checker0 (
    .clk_i (clk), .rst_ni (rst_n),
    .rvalid_i (host_rvalid), .rdata_i (host_rdata), .err_i (host_err),
    .debug_req_i (debug_req), .exit_i (exit_code),
    .exp_valid_i (exp_valid), .exp_data_i (exp_data), .exp_err_i (exp_err),
    .exp_debug_i (exp_debug), .exp_exit_i (exp_exit),
    .test_done_i (test_done), .test_id_i (test_id),
    .errors_o (err_cnt), .checks_o (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Stimulus file and reference model
  // ----------------------------------------------------------------------
  task automatic load_ops(output bit ok);
    int    fd;
    int    n;
    string line;
    op_t   o;
    ok = 1'b0;
    fd = $fopen("sim/harness_stimulus.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%d %c %h %h %h %h %h",
                  o.test, o.op, o.a0, o.a1, o.a2, o.exp_data, o.exp_flag);
      if (n == 7) ops.push_back(o);
    end
    $fclose(fd);
    ok = (ops.size() > 0);
  endtask

  // RAM is indexed by word offset from RamBase
  task automatic check_model(input op_t o);
    addr_t rom_off;
    addr_t ram_off;
    logic  in_rom;
    logic  in_ram;
    logic  err_pred;
    data_t pred;
    rom_off  = o.a0 - RomBase;
    ram_off  = o.a0 - RamBase;
    in_rom   = rom_off < RomWords * StrbWidth;
    in_ram   = ram_off < RamWords * StrbWidth;
    err_pred = !(in_ram || (in_rom && o.op == "R"));
    pred     = '0;
    if (!err_pred && o.op == "W") begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (o.a1[b]) ram_model[ram_off >> 2][b*8 +: 8] = o.a2[b*8 +: 8];
      end
    end else if (!err_pred) begin
      pred = in_rom ? RomImage[rom_off >> 2] : ram_model[ram_off >> 2];
    end
    if (pred !== o.exp_data || err_pred !== o.exp_flag) begin
      $display("Stimulus for test %0d at address %h disagrees with the reference model",
               o.test, o.a0);
      model_errs++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Driver
  // ----------------------------------------------------------------------
  task automatic clear_strobes();
    host_req  = 1'b0;
    jtag_req  = 1'b0;
    dmi_req   = 1'b0;
    exp_valid = 1'b0;
    exp_err   = 1'b0;
    exp_debug = 1'b0;
    exp_data  = '0;
  endtask

  task automatic apply_op(input op_t o);
    clear_strobes();
    case (o.op)
      "R", "W": begin
        host_req   = 1'b1;
        host_we    = (o.op == "W");
        host_addr  = o.a0;
        host_be    = o.a1[StrbWidth-1:0];
        host_wdata = o.a2;
        exp_valid  = 1'b1;
        exp_data   = o.exp_data;
        exp_err    = o.exp_flag;
        check_model(o);
      end
      "J": begin
        jtag_req  = 1'b1;
        exp_debug = o.exp_flag;
      end
      "D": begin
        dmi_req   = 1'b1;
        exp_debug = o.exp_flag;
      end
      "S": begin
        jtag_sel  = o.a0[0];
        jtag_exit = o.a1;
        dmi_exit  = o.a2;
        exp_exit  = o.exp_data;
      end
      "I": repeat (o.a0) @(posedge clk);
      default: begin
        $display("Unknown operation %c in test %0d", o.op, o.test);
        model_errs++;
      end
    endcase
  endtask

  // One idle cycle lets the last response reach the checker
  task automatic end_test(input int id);
    @(posedge clk);
    #2;
    clear_strobes();
    test_id   = id;
    test_done = 1'b1;
    @(posedge clk);
    #2;
    test_done = 1'b0;
  endtask

  initial begin
    bit ok;
    int prev_test;
    void'($urandom(32'h2739));
    rst_n     = 1'b0;
    host_we   = 1'b0;
    host_addr = '0;
    host_be   = '0;
    host_wdata = '0;
    jtag_sel  = 1'b0;
    jtag_exit = '0;
    dmi_exit  = '0;
    exp_exit  = '0;
    test_done = 1'b0;
    test_id   = 0;
    clear_strobes();
    load_ops(ok);
    if (!ok) begin
      $display("Could not read any operation from the stimulus file");
      $display("Verification failed");
      $finish;
    end else begin
      ops_loaded = 1'b1;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      prev_test = ops[0].test;
      foreach (ops[i]) begin
        if (ops[i].test != prev_test) begin
          end_test(prev_test);
          repeat ($urandom % 3) @(posedge clk);
          prev_test = ops[i].test;
        end
        @(posedge clk);
        #2;
        apply_op(ops[i]);
      end
      end_test(prev_test);
      $display("Checks: %0d, checker errors: %0d, model errors: %0d",
               chk_cnt, err_cnt, model_errs);
      if (err_cnt == 0 && model_errs == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (ops_loaded);
    #((ops.size() + DebugHoldCycles + 50) * 20);
    $display("Timeout: the operations did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

// File: sim/harness_stimulus.txt
# test op arg0 arg1 arg2 exp_data exp_flag; test is decimal, the rest hex
# R/W: addr be wdata, flag is error; J/D: strobe, flag is debug_req; S: sel jtag_exit dmi_exit; I: cycles
1 S 00000001 00000011 00000022 00000011 0
1 J 00000000 00000000 00000000 00000000 0
1 D 00000000 00000000 00000000 00000000 0
1 J 00000000 00000000 00000000 00000000 0
1 I 00000020 00000000 00000000 00000000 0
2 J 00000000 00000000 00000000 00000000 1
2 D 00000000 00000000 00000000 00000000 0
2 S 00000000 00000011 00000022 00000022 0
2 D 00000000 00000000 00000000 00000000 1
2 J 00000000 00000000 00000000 00000000 0
2 S 00000001 0000cafe 0000f00d 0000cafe 0
3 R 00001000 00000000 00000000 00000297 0
3 R 00001004 00000000 00000000 01828293 0
3 R 00001008 00000000 00000000 0002a303 0
3 R 0000100c 00000000 00000000 00100093 0
3 R 00001010 00000000 00000000 00030067 0
3 R 00001014 00000000 00000000 00000013 0
3 R 00001018 00000000 00000000 80000000 0
3 R 0000101c 00000000 00000000 deadbeef 0
4 W 80000010 0000000f 11223344 00000000 0
4 W 80000010 00000001 000000aa 00000000 0
4 W 80000010 00000004 00bb0000 00000000 0
4 R 80000010 00000000 00000000 11bb33aa 0
5 R 00000000 00000000 00000000 00000000 1
5 W 00001008 0000000f deadbeef 00000000 1
5 W 80000400 0000000f 12345678 00000000 1
5 R 00001008 00000000 00000000 0002a303 0

// File: tb.f
logic/harness_pkg.sv
logic/addr_decoder.sv
logic/bootrom.sv
logic/sram_bank.sv
logic/mem_subsystem.sv
logic/debug_port.sv
logic/soc_harness.sv
sim/harness_checker.sv
sim/tb_soc_harness.sv

// File: Bender.yml
package:
  name: soc_harness

sources:
  - logic/harness_pkg.sv
  - logic/addr_decoder.sv
  - logic/bootrom.sv
  - logic/sram_bank.sv
  - logic/mem_subsystem.sv
  - logic/debug_port.sv
  - logic/soc_harness.sv
  - target: simulation
    files:
      - sim/harness_checker.sv
      - sim/tb_soc_harness.sv
